/* common/spmmio_pkg.sv */
package spmmio_pkg;

   // device codes in the top byte of the address
   typedef enum logic [0:7] {
      DEV_MISC = 8'h00,
      DEV_KBD  = 8'h04
   } spmmio_dev_e;

   typedef enum logic [0:3] {
      MISC_LED     = 4'd0,
      MISC_SCRATCH = 4'd1,
      MISC_SWRST   = 4'd2,
      MISC_ID      = 4'd3
   } misc_reg_e;

   typedef enum logic [0:3] {
      KBD_STATUS = 4'd0,
      KBD_DATA   = 4'd1
   } kbd_reg_e;

   // one request as seen by a device, bit 0 is the msb throughout
   typedef struct packed {
      logic [0:3]  reg_idx;
      logic [0:3]  sel;
      logic        we;
      logic [0:31] dat;
   } bus_req_t;

   // shift state sits above the key code when packed into a word
   typedef struct packed {
      logic [0:3] shift;
      logic [0:6] code;
   } kbd_entry_t;

   localparam logic [0:31] SPMMIO_ID = 32'h5350_4d31; // ascii "SPM1"

endpackage

/* keyboard/kbd_fifo.sv */
`timescale 1ns/1ps

module kbd_fifo #(
   parameter int DEPTH = 8
) (
   input  logic                    clk,
   input  logic                    rst_i,
   input  logic                    push_i,
   input  spmmio_pkg::kbd_entry_t  din_i,
   input  logic                    pop_i,
   output spmmio_pkg::kbd_entry_t  dout_o,
   output logic [0:6]              count_o,
   output logic                    full_o,
   output logic                    empty_o
);

   import spmmio_pkg::*;

   localparam int AW = $clog2(DEPTH);

   kbd_entry_t    mem [DEPTH];
   logic [AW-1:0] wr_ptr_q;
   logic [AW-1:0] rd_ptr_q;
   logic [6:0]    count_q;
   logic          do_push;
   logic          do_pop;

   assign full_o  = (count_q == 7'(DEPTH));
   assign empty_o = (count_q == 7'd0);

   // when full a push only lands if the head leaves in the same cycle
   assign do_push = push_i && (!full_o || pop_i);
   assign do_pop  = pop_i && !empty_o;

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr_q] <= din_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1; // depth is a power of two so this wraps
         end
         if (do_pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 7'd1;
            2'b01:   count_q <= count_q - 7'd1;
            default: count_q <= count_q;
         endcase
      end
   end

   assign dout_o  = mem[rd_ptr_q];
   assign count_o = count_q;

   a_no_pop_empty : assert property (@(posedge clk) disable iff (rst_i)
      pop_i |-> !empty_o)
      else $error("pop while fifo empty");

   a_count_max : assert property (@(posedge clk) disable iff (rst_i)
      count_q <= 7'(DEPTH))
      else $error("fifo count above depth");

endmodule

/* keyboard/spmmio_keyboard.sv */
`timescale 1ns/1ps

module spmmio_keyboard #(
   parameter int KBD_DEPTH = 8
) (
   input  logic                  clk,
   input  logic                  rst_i,
   input  logic                  cs_i,
   input  spmmio_pkg::bus_req_t  req_i,
   output logic [0:31]           q_o,
   input  logic                  keypress_i,
   input  logic [0:6]            keycode_i,
   input  logic [0:3]            shift_state_i,
   output logic                  irq_o
);

   import spmmio_pkg::*;

   kbd_reg_e   reg_sel;
   kbd_entry_t key_entry;
   kbd_entry_t head;
   logic [0:6] count;
   logic       full;
   logic       empty;
   logic       pop;
   logic       ovf_q;
   logic       ovf_clr;
   logic       key_lost;

   assign reg_sel = kbd_reg_e'(req_i.reg_idx);

   assign key_entry = '{shift: shift_state_i, code: keycode_i};

   // a data read takes the head away, but only if there is one
   assign pop = cs_i && !req_i.we && (reg_sel == KBD_DATA) && !empty;

   assign ovf_clr  = cs_i && req_i.we && (reg_sel == KBD_STATUS) && req_i.dat[29];
   assign key_lost = keypress_i && full && !pop;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         ovf_q <= 1'b0;
      end else if (key_lost) begin
         ovf_q <= 1'b1; // a fresh loss wins over a clear in the same cycle
      end else if (ovf_clr) begin
         ovf_q <= 1'b0;
      end
   end

   kbd_fifo #(
      .DEPTH (KBD_DEPTH)
   ) fifo (
      .clk     (clk),
      .rst_i   (rst_i),
      .push_i  (keypress_i),
      .din_i   (key_entry),
      .pop_i   (pop),
      .dout_o  (head),
      .count_o (count),
      .full_o  (full),
      .empty_o (empty)
   );

   always_comb begin
      q_o = '0;
      case (reg_sel)
         KBD_STATUS: begin
            q_o[16:23] = {1'b0, count};
            q_o[29]    = ovf_q;
            q_o[30]    = full;
            q_o[31]    = empty;
         end
         KBD_DATA: begin
            if (!empty) begin
               q_o[21:31] = head;
            end
         end
         default: q_o = '0;
      endcase
   end

   assign irq_o = !empty;

endmodule

/* logic/spmmio_misc.sv */
`timescale 1ns/1ps

module spmmio_misc (
   input  logic                  clk,
   input  logic                  rst_i,
   input  logic                  cs_i,
   input  spmmio_pkg::bus_req_t  req_i,
   output logic [0:31]           q_o,
   output logic                  led_red_o,
   output logic                  led_green_o,
   output logic [0:4]            sw_reset_o
);

   import spmmio_pkg::*;

   misc_reg_e   reg_sel;
   logic        wr;
   logic        led_red_q;
   logic        led_green_q;
   logic [0:31] scratch_q;
   logic [0:4]  sw_reset_q;

   assign reg_sel = misc_reg_e'(req_i.reg_idx);
   assign wr      = cs_i && req_i.we;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         led_red_q   <= 1'b0;
         led_green_q <= 1'b0;
      end else if (wr && reg_sel == MISC_LED && req_i.sel[3]) begin
         led_red_q   <= req_i.dat[31];
         led_green_q <= req_i.dat[30];
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         scratch_q <= '0;
      end else if (wr && reg_sel == MISC_SCRATCH) begin
         for (int i = 0; i < 4; i++) begin
            if (req_i.sel[i]) begin
               scratch_q[8*i +: 8] <= req_i.dat[8*i +: 8];
            end
         end
      end
   end

   // the pulse lasts one cycle, any other cycle loads zero
   always_ff @(posedge clk) begin
      if (rst_i) begin
         sw_reset_q <= '0;
      end else if (wr && reg_sel == MISC_SWRST) begin
         sw_reset_q <= req_i.dat[27:31];
      end else begin
         sw_reset_q <= '0;
      end
   end

   always_comb begin
      q_o = '0;
      case (reg_sel)
         MISC_LED: begin
            q_o[31] = led_red_q;
            q_o[30] = led_green_q;
         end
         MISC_SCRATCH: q_o = scratch_q;
         MISC_ID:      q_o = SPMMIO_ID;
         default:      q_o = '0; // swrst and unused indices
      endcase
   end

   assign led_red_o   = led_red_q;
   assign led_green_o = led_green_q;
   assign sw_reset_o  = sw_reset_q;

   a_swrst_pulse : assert property (@(posedge clk) disable iff (rst_i)
      (sw_reset_o != '0) |=> (sw_reset_o == '0))
      else $error("sw_reset_o held for more than one cycle");

endmodule

/* spmmio/spmmio.sv */
`timescale 1ns/1ps

module spmmio #(
   parameter int KBD_DEPTH = 8
) (
   input  logic        clk,
   input  logic        rst_i,

   input  logic [0:23] adr_i, // bit 21 is the least significant word address bit
   input  logic        stb_i,
   input  logic        cyc_i,
   input  logic [0:3]  sel_i,
   input  logic        we_i,
   input  logic [0:31] dat_i,
   output logic        ack_o,
   output logic [0:31] dat_o,

   output logic        led_red_o,
   output logic        led_green_o,
   output logic [0:4]  sw_reset_o,

   input  logic        keypress_i,
   input  logic [0:6]  keycode_i,
   input  logic [0:3]  shift_state_i,
   output logic        kbd_irq_o
);

   import spmmio_pkg::*;

   spmmio_dev_e dev;
   bus_req_t    req;
   logic        cs_misc;
   logic        cs_kbd;
   logic [0:31] q_misc;
   logic [0:31] q_kbd;

   assign dev = spmmio_dev_e'(adr_i[0:7]);

   assign req = '{reg_idx: adr_i[18:21], sel: sel_i, we: we_i, dat: dat_i};

   assign cs_misc = cyc_i && stb_i && (dev == DEV_MISC);
   assign cs_kbd  = cyc_i && stb_i && (dev == DEV_KBD);

   // every access completes in the strobe cycle
   assign ack_o = stb_i;

   always_comb begin
      case (dev)
         DEV_MISC: dat_o = q_misc;
         DEV_KBD:  dat_o = q_kbd;
         default:  dat_o = '0; // unmapped codes read as zero
      endcase
   end

   spmmio_misc misc (
      .clk         (clk),
      .rst_i       (rst_i),
      .cs_i        (cs_misc),
      .req_i       (req),
      .q_o         (q_misc),
      .led_red_o   (led_red_o),
      .led_green_o (led_green_o),
      .sw_reset_o  (sw_reset_o)
   );

   spmmio_keyboard #(
      .KBD_DEPTH (KBD_DEPTH)
   ) keyboard (
      .clk           (clk),
      .rst_i         (rst_i),
      .cs_i          (cs_kbd),
      .req_i         (req),
      .q_o           (q_kbd),
      .keypress_i    (keypress_i),
      .keycode_i     (keycode_i),
      .shift_state_i (shift_state_i),
      .irq_o         (kbd_irq_o)
   );

   a_one_cs : assert property (@(posedge clk) disable iff (rst_i)
      $onehot0({cs_misc, cs_kbd}))
      else $error("both device selects high at once");

endmodule

/* dv/spmmio_tb_model.svh */
`ifndef SPMMIO_TB_MODEL_SVH
`define SPMMIO_TB_MODEL_SVH

localparam int MODEL_DEPTH = 8; // matches the KBD_DEPTH given to uut

logic        m_led_red;
logic        m_led_green;
logic [0:31] m_scratch;
logic [0:4]  m_swrst; // value sw_reset_o should show in the current cycle
logic        m_ovf;
kbd_entry_t  m_fifo[$];

function automatic void reset_model();
   m_led_red   = 1'b0;
   m_led_green = 1'b0;
   m_scratch   = '0;
   m_swrst     = '0;
   m_ovf       = 1'b0;
   m_fifo.delete();
endfunction

// only the bytes whose enable is set take the new data
function automatic logic [0:31] merge_bytes(input logic [0:31] old, input logic [0:31] wdat,
                                            input logic [0:3] sel);
   logic [0:31] mask;
   mask = {{8{sel[0]}}, {8{sel[1]}}, {8{sel[2]}}, {8{sel[3]}}};
   return (wdat & mask) | (old & ~mask);
endfunction

// read data as seen during the access cycle, before its edge
function automatic logic [0:31] expected_read(input logic [0:23] adr);
   logic [0:31] v;
   v = '0;
   if (adr[0:7] == DEV_MISC) begin
      case (adr[18:21])
         MISC_LED: begin
            v[30] = m_led_green;
            v[31] = m_led_red;
         end
         MISC_SCRATCH: v = m_scratch;
         MISC_ID:      v = SPMMIO_ID;
         default:      v = '0;
      endcase
   end else if (adr[0:7] == DEV_KBD) begin
      if (adr[18:21] == KBD_STATUS) begin
         v[16:23] = 8'(m_fifo.size());
         v[29]    = m_ovf;
         v[30]    = (m_fifo.size() == MODEL_DEPTH);
         v[31]    = (m_fifo.size() == 0);
      end else if (adr[18:21] == KBD_DATA && m_fifo.size() != 0) begin
         v[21:31] = m_fifo[0];
      end
   end
   return v;
endfunction

// advances the model across one rising edge
function automatic void step_model(input logic cs, input logic [0:23] adr,
                                   input logic [0:3] sel, input logic we,
                                   input logic [0:31] dat, input logic key,
                                   input kbd_entry_t entry);
   logic pop;
   logic clr;
   logic lost;
   pop  = cs && !we && adr[0:7] == DEV_KBD && adr[18:21] == KBD_DATA && m_fifo.size() != 0;
   clr  = cs && we && adr[0:7] == DEV_KBD && adr[18:21] == KBD_STATUS && dat[29];
   lost = key && m_fifo.size() == MODEL_DEPTH && !pop; // a pop frees the slot first
   m_swrst = '0;
   if (cs && we && adr[0:7] == DEV_MISC) begin
      case (adr[18:21])
         MISC_LED: begin
            if (sel[3]) begin
               m_led_red   = dat[31];
               m_led_green = dat[30];
            end
         end
         MISC_SCRATCH: m_scratch = merge_bytes(m_scratch, dat, sel);
         MISC_SWRST:   m_swrst = dat[27:31];
         default: ;
      endcase
   end
   if (pop) begin
      void'(m_fifo.pop_front());
   end
   if (key && !lost) begin
      m_fifo.push_back(entry);
   end
   if (lost) begin
      m_ovf = 1'b1;
   end else if (clr) begin
      m_ovf = 1'b0;
   end
endfunction

`endif

/* dv/tb_spmmio.sv */
`timescale 1ns/1ps

module tb_spmmio;

   import spmmio_pkg::*;

   `include "spmmio_tb_model.svh"

   localparam int TIMEOUT_CYCLES = 2000; // the six tests need well under 600 cycles

   logic        clk;
   logic        rst_i;
   logic [0:23] adr_i;
   logic        stb_i;
   logic        cyc_i;
   logic [0:3]  sel_i;
   logic        we_i;
   logic [0:31] dat_i;
   logic        ack_o;
   logic [0:31] dat_o;
   logic        led_red_o;
   logic        led_green_o;
   logic [0:4]  sw_reset_o;
   logic        keypress_i;
   logic [0:6]  keycode_i;
   logic [0:3]  shift_state_i;
   logic        kbd_irq_o;

   kbd_entry_t  key_in;
   logic [0:31] exp_rd;
   logic [0:31] rd_data; // data captured by the last bus access
   int          errors = 0;
   int          checks = 0;

   spmmio #(
      .KBD_DEPTH (8)
   ) uut (
      .clk           (clk),
      .rst_i         (rst_i),
      .adr_i         (adr_i),
      .stb_i         (stb_i),
      .cyc_i         (cyc_i),
      .sel_i         (sel_i),
      .we_i          (we_i),
      .dat_i         (dat_i),
      .ack_o         (ack_o),
      .dat_o         (dat_o),
      .led_red_o     (led_red_o),
      .led_green_o   (led_green_o),
      .sw_reset_o    (sw_reset_o),
      .keypress_i    (keypress_i),
      .keycode_i     (keycode_i),
      .shift_state_i (shift_state_i),
      .kbd_irq_o     (kbd_irq_o)
   );

   assign key_in = '{shift: shift_state_i, code: keycode_i};

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("timeout after %0d cycles, the stimulus never finished", TIMEOUT_CYCLES);
      $display("checks=%0d errors=%0d", checks, errors + 1);
      $display("Test failed");
      $finish;
   end

   task automatic report_mismatch(input string name, input logic [0:31] exp,
                                  input logic [0:31] got);
      errors++;
      $display("FAIL time=%0t %s expected %h got %h", $time, name, exp, got);
   endtask

   // outputs are stable at the falling edge, the model then steps over the next rise
   always @(negedge clk) begin
      if (rst_i) begin
         reset_model();
      end else begin
         checks++;
         if (ack_o !== stb_i) report_mismatch("ack_o", stb_i, ack_o);
         if (cyc_i && stb_i && !we_i) begin
            exp_rd = expected_read(adr_i);
            if (dat_o !== exp_rd) report_mismatch("dat_o", exp_rd, dat_o);
         end
         if (led_red_o !== m_led_red) report_mismatch("led_red_o", m_led_red, led_red_o);
         if (led_green_o !== m_led_green) report_mismatch("led_green_o", m_led_green, led_green_o);
         if (sw_reset_o !== m_swrst) report_mismatch("sw_reset_o", m_swrst, sw_reset_o);
         if (kbd_irq_o !== (m_fifo.size() != 0)) begin
            report_mismatch("kbd_irq_o", m_fifo.size() != 0, kbd_irq_o);
         end
         step_model(cyc_i && stb_i, adr_i, sel_i, we_i, dat_i, keypress_i, key_in);
      end
   end

   task automatic bus_access(input logic cyc, input logic we, input logic [0:7] dev,
                             input logic [0:3] idx, input logic [0:3] sel,
                             input logic [0:31] dat);
      @(posedge clk);
      adr_i <= {dev, 10'd0, idx, 2'd0};
      cyc_i <= cyc;
      stb_i <= 1'b1;
      we_i  <= we;
      sel_i <= sel;
      dat_i <= dat;
      @(negedge clk);
      rd_data = dat_o;
      if (ack_o !== 1'b1) report_mismatch("ack_o", 32'h1, ack_o);
      @(posedge clk);
      cyc_i <= 1'b0;
      stb_i <= 1'b0;
      we_i  <= 1'b0;
   endtask

   task automatic bus_write(input logic [0:7] dev, input logic [0:3] idx,
                            input logic [0:3] sel, input logic [0:31] dat);
      bus_access(1'b1, 1'b1, dev, idx, sel, dat);
   endtask

   task automatic bus_read(input logic [0:7] dev, input logic [0:3] idx);
      bus_access(1'b1, 1'b0, dev, idx, 4'hf, 32'h0);
   endtask

   task automatic expect_read(input logic [0:7] dev, input logic [0:3] idx,
                              input logic [0:31] exp, input string name);
      bus_read(dev, idx);
      if (rd_data !== exp) report_mismatch(name, exp, rd_data);
   endtask

   task automatic send_key(input logic [0:3] shift, input logic [0:6] code);
      @(posedge clk);
      keypress_i    <= 1'b1;
      shift_state_i <= shift;
      keycode_i     <= code;
      @(posedge clk);
      keypress_i    <= 1'b0;
   endtask

   initial begin
      logic [0:7] dev;
      void'($urandom(32'ha690_14a9));
      rst_i         = 1'b1;
      adr_i         = '0;
      stb_i         = 1'b0;
      cyc_i         = 1'b0;
      sel_i         = '0;
      we_i          = 1'b0;
      dat_i         = '0;
      keypress_i    = 1'b0;
      keycode_i     = '0;
      shift_state_i = '0;
      repeat (10) @(posedge clk);
      rst_i <= 1'b0;

      expect_read(DEV_MISC, MISC_LED, 32'h0, "led register after reset");
      expect_read(DEV_MISC, MISC_SCRATCH, 32'h0, "scratch after reset");
      expect_read(DEV_MISC, MISC_ID, SPMMIO_ID, "id register");
      expect_read(DEV_KBD, KBD_STATUS, 32'h0000_0001, "kbd status after reset");

      repeat (24) begin
         bus_write(DEV_MISC, MISC_SCRATCH, 4'($urandom), $urandom);
         bus_read(DEV_MISC, MISC_SCRATCH);
      end
      repeat (8) begin
         bus_write(DEV_MISC, MISC_LED, 4'($urandom), $urandom);
         bus_read(DEV_MISC, MISC_LED);
      end

      repeat (12) begin
         bus_write(DEV_MISC, MISC_SWRST, 4'hf, $urandom);
         repeat ($urandom_range(0, 3)) @(posedge clk);
      end

      repeat (6) begin
         send_key(4'($urandom), 7'($urandom));
         repeat ($urandom_range(0, 4)) @(posedge clk);
         bus_read(DEV_KBD, KBD_STATUS);
      end
      repeat (7) bus_read(DEV_KBD, KBD_DATA); // the last one finds the queue empty
      if (rd_data !== 32'h0) report_mismatch("dat_o on empty data read", 32'h0, rd_data);

      repeat (10) send_key(4'($urandom), 7'($urandom));
      expect_read(DEV_KBD, KBD_STATUS, 32'h0000_0806, "status when full with overflow");
      bus_write(DEV_KBD, KBD_STATUS, 4'hf, 32'h0000_0004);
      expect_read(DEV_KBD, KBD_STATUS, 32'h0000_0802, "status after overflow clear");
      repeat (9) bus_read(DEV_KBD, KBD_DATA);
      expect_read(DEV_KBD, KBD_STATUS, 32'h0000_0001, "status after drain");

      repeat (10) begin
         do begin
            dev = 8'($urandom);
         end while (dev == DEV_MISC || dev == DEV_KBD);
         bus_write(dev, 4'($urandom), 4'($urandom), $urandom);
         expect_read(dev, 4'($urandom), 32'h0, "unmapped device read");
      end
      // strobe without a bus cycle must leave the registers alone
      bus_access(1'b0, 1'b1, DEV_MISC, MISC_SCRATCH, 4'hf, $urandom);
      bus_access(1'b0, 1'b1, DEV_MISC, MISC_LED, 4'hf, 32'h0000_0003);
      bus_access(1'b0, 1'b1, DEV_MISC, MISC_SWRST, 4'hf, 32'h0000_001f);
      bus_read(DEV_MISC, MISC_SCRATCH);
      repeat (6) @(posedge clk);

      $display("checks=%0d errors=%0d", checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* build.f */
+incdir+dv
common/spmmio_pkg.sv
keyboard/kbd_fifo.sv
keyboard/spmmio_keyboard.sv
logic/spmmio_misc.sv
spmmio/spmmio.sv
dv/tb_spmmio.sv
